// File: logic/tdc_macros.svh
`ifndef TDC_MACROS_SVH
`define TDC_MACROS_SVH

// ----------------------------------------
// dll and coarse counter geometry
// ----------------------------------------
`define TDC_TAPS      32   // dll phase taps
`define TDC_FINE_W    5    // fine time bits
`define TDC_COARSE_W  10   // coarse count bits
`define TDC_TOF_W     15   // time of flight and range

// ----------------------------------------
// spad array and per-frame limits
// ----------------------------------------
`define TDC_SPADS     16   // 4x4 spad enables
`define TDC_INT_W     4    // saturated intensity
`define TDC_MAX_HITS  3    // hits kept per frame
`define TDC_NO_HIT    15'h7fff

`endif

// File: logic/tdc_hit_pkg.sv
`default_nettype none

`include "tdc_macros.svh"

// capture side of the tdc, what one stop strobe leaves behind
package tdc_hit_pkg;

    typedef logic [`TDC_TAPS-1:0]     phase_t;   // raw thermometer taps
    typedef logic [`TDC_FINE_W-1:0]   fine_t;
    typedef logic [`TDC_COARSE_W-1:0] coarse_t;
    typedef logic [`TDC_SPADS-1:0]    spad_t;

    // one recorded hit, 31 bits
    typedef struct packed {
        coarse_t coarse;
        fine_t   fine;     // stop phase
        spad_t   spad;     // enables seen on the hit cycle
    } hit_t;

    typedef logic [1:0] slot_idx_t;   // buffer slot 0..2

endpackage

`default_nettype wire

// File: logic/tdc_out_pkg.sv
`default_nettype none

`include "tdc_macros.svh"

// result side, what leaves on the output burst
package tdc_out_pkg;

    typedef logic [`TDC_TOF_W-1:0] tof_t;        // also the range format
    typedef logic [`TDC_INT_W-1:0] intensity_t;
    typedef logic [1:0]            hit_cnt_t;    // 0..3 hits

    typedef struct packed {
        tof_t       tof;
        intensity_t intensity;
    } result_t;

endpackage

`default_nettype wire

// File: logic/tdc_frame_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "tdc_macros.svh"

module tdc_frame_ctrl import tdc_hit_pkg::*, tdc_out_pkg::*; (
    input  wire     clk,
    input  wire     rst_n,
    input  wire     start_i,
    input  tof_t    range_i,
    input  wire     burst_done_i,
    output logic    frame_start_o,
    output logic    active_o,
    output coarse_t coarse_o,
    output logic    frame_end_o,
    output tof_t    range_o
);

    logic    busy_q;     // start accepted, burst not yet out
    logic    active_q;
    coarse_t coarse_q;
    coarse_t coarse_nxt;
    tof_t    range_q;
    logic    at_end;

    assign frame_start_o = start_i && !busy_q;   // starts during a frame are ignored

    // hits see the count after this cycle's increment
    assign coarse_nxt = coarse_q + 1'b1;
    assign at_end     = active_q && (coarse_nxt == range_q[`TDC_TOF_W-1:`TDC_FINE_W]);

    assign active_o    = active_q && !at_end;   // last coarse cycle takes no hit
    assign frame_end_o = at_end;
    assign coarse_o    = coarse_nxt;
    assign range_o     = range_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q   <= 1'b0;
            active_q <= 1'b0;
            coarse_q <= '0;
            range_q  <= '0;
        end else if (frame_start_o) begin
            busy_q   <= 1'b1;
            active_q <= 1'b1;
            coarse_q <= '0;
            range_q  <= range_i;
        end else begin
            if (active_q) begin
                coarse_q <= coarse_nxt;
                if (at_end)
                    active_q <= 1'b0;
            end
            if (burst_done_i)
                busy_q <= 1'b0;   // readout finished, open for next start
        end
    end

endmodule

`default_nettype wire

// File: logic/tdc_hit_capture.sv
`timescale 1ns/1ps
`default_nettype none

`include "tdc_macros.svh"

module tdc_hit_capture import tdc_hit_pkg::*, tdc_out_pkg::*; (
    input  wire       clk,
    input  wire       rst_n,
    input  wire       frame_start_i,
    input  wire       active_i,
    input  wire       hit_i,
    input  phase_t    phase_i,
    input  spad_t     spad_i,
    input  coarse_t   coarse_i,
    output logic      wr_en_o,
    output slot_idx_t wr_idx_o,
    output hit_t      wr_hit_o,
    output fine_t     start_fine_o,
    output hit_cnt_t  hit_cnt_o
);

    // ----------------------------------------
    // thermometer decode
    // ----------------------------------------
    // run of ones from tap 0, a full row saturates
    function automatic fine_t therm_decode(input phase_t taps);
        logic [`TDC_FINE_W:0] ones;
        logic                 run;
        ones = '0;
        run  = 1'b1;
        for (int i = 0; i < `TDC_TAPS; i++) begin
            run  = run & taps[i];   // first zero ends the run
            ones = ones + {{`TDC_FINE_W{1'b0}}, run};
        end
        return ones[`TDC_FINE_W] ? '1 : ones[`TDC_FINE_W-1:0];
    endfunction

    fine_t    phase_fine;
    fine_t    start_fine_q;
    hit_cnt_t hit_cnt_q;
    logic     take_hit;

    assign phase_fine = therm_decode(phase_i);
    assign take_hit   = hit_i && active_i && (hit_cnt_q < `TDC_MAX_HITS);   // 4th hit dropped

    // ----------------------------------------
    // hit record, written in the strobe cycle
    // ----------------------------------------
    assign wr_en_o  = take_hit;
    assign wr_idx_o = hit_cnt_q;   // next free slot
    assign wr_hit_o = '{coarse: coarse_i, fine: phase_fine, spad: spad_i};

    assign start_fine_o = start_fine_q;
    assign hit_cnt_o    = hit_cnt_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_fine_q <= '0;
            hit_cnt_q    <= '0;
        end else if (frame_start_i) begin
            start_fine_q <= phase_fine;   // dll phase at the start strobe
            hit_cnt_q    <= '0;
        end else if (take_hit) begin
            hit_cnt_q <= hit_cnt_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/tdc_slot_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "tdc_macros.svh"

// small indexed store, one writer and one reader
module tdc_slot_buffer import tdc_hit_pkg::*; #(
    parameter type payload_t = logic
) (
    input  wire       clk,
    input  wire       rst_n,
    input  wire       wr_en_i,
    input  slot_idx_t wr_idx_i,
    input  payload_t  wr_data_i,
    input  slot_idx_t rd_idx_i,
    output payload_t  rd_data_o
);

    payload_t slots_q [`TDC_MAX_HITS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `TDC_MAX_HITS; i++) begin
                slots_q[i] <= '0;
            end
        end else if (wr_en_i && (wr_idx_i < `TDC_MAX_HITS)) begin
            slots_q[wr_idx_i] <= wr_data_i;
        end
    end

    // async read, index 3 has no slot behind it
    assign rd_data_o = (rd_idx_i < `TDC_MAX_HITS) ? slots_q[rd_idx_i] : '0;

endmodule

`default_nettype wire

// File: logic/tdc_result_calc.sv
`timescale 1ns/1ps
`default_nettype none

`include "tdc_macros.svh"

module tdc_result_calc import tdc_hit_pkg::*, tdc_out_pkg::*; (
    input  wire       clk,
    input  wire       rst_n,
    input  wire       frame_end_i,
    input  hit_cnt_t  hit_cnt_i,
    input  fine_t     start_fine_i,
    input  tof_t      range_i,
    output slot_idx_t rd_idx_o,
    input  hit_t      hit_i,
    output logic      wr_en_o,
    output slot_idx_t wr_idx_o,
    output result_t   wr_result_o,
    output logic      calc_done_o,
    output hit_cnt_t  count_o
);

    // active spads, clipped to what the intensity field holds
    function automatic intensity_t spad_level(input spad_t en);
        logic [`TDC_INT_W:0] sum;
        sum = '0;
        for (int i = 0; i < `TDC_SPADS; i++) begin
            sum = sum + {{`TDC_INT_W{1'b0}}, en[i]};
        end
        return sum[`TDC_INT_W] ? '1 : sum[`TDC_INT_W-1:0];
    endfunction

    logic                busy_q;
    slot_idx_t           idx_q;    // slot being worked on
    hit_cnt_t            cnt_q;    // hits in this frame
    logic                slot_pending;
    logic [`TDC_TOF_W:0] raw_tof;  // one spare bit catches wrap
    tof_t                tof_val;

    assign slot_pending = busy_q && (idx_q != cnt_q);

    // ----------------------------------------
    // time of flight, one slot per cycle
    // ----------------------------------------
    // coarse * 32 + stop - start
    assign raw_tof = {1'b0, hit_i.coarse, hit_i.fine}
                   - {{(`TDC_TOF_W + 1 - `TDC_FINE_W){1'b0}}, start_fine_i};

    always_comb begin
        if (raw_tof > {1'b0, range_i})
            tof_val = `TDC_NO_HIT;   // beyond the range window
        else
            tof_val = raw_tof[`TDC_TOF_W-1:0];
    end

    assign rd_idx_o    = idx_q;
    assign wr_en_o     = slot_pending;
    assign wr_idx_o    = idx_q;
    assign wr_result_o = '{tof: tof_val, intensity: spad_level(hit_i.spad)};

    // done once every slot is written, next cycle for an empty frame
    assign calc_done_o = busy_q && (idx_q == cnt_q);
    assign count_o     = cnt_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            idx_q  <= '0;
            cnt_q  <= '0;
        end else if (frame_end_i) begin
            busy_q <= 1'b1;
            idx_q  <= '0;
            cnt_q  <= hit_cnt_i;
        end else if (slot_pending) begin
            idx_q <= idx_q + 1'b1;
        end else if (calc_done_o) begin
            busy_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: logic/tdc_readout.sv
`timescale 1ns/1ps
`default_nettype none

`include "tdc_macros.svh"

module tdc_readout import tdc_hit_pkg::*, tdc_out_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        calc_done_i,
    input  hit_cnt_t   count_i,
    output slot_idx_t  rd_idx_o,
    input  result_t    result_i,
    output tof_t       tof_o,
    output intensity_t int_o,
    output hit_cnt_t   num_o,
    output logic       last_o,
    output logic       valid_o,
    output logic       burst_done_o
);

    typedef enum logic {
        RD_IDLE,
        RD_SEND
    } rd_state_e;

    rd_state_e  state_q;
    slot_idx_t  idx_q;     // slot feeding the next beat
    hit_cnt_t   cnt_q;
    tof_t       tof_q;
    intensity_t int_q;
    hit_cnt_t   num_q;
    logic       last_q;
    logic       valid_q;

    assign rd_idx_o = idx_q;   // sits at 0 while idle, so slot 0 is ready on calc_done

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= RD_IDLE;
            idx_q   <= '0;
            cnt_q   <= '0;
            tof_q   <= '0;
            int_q   <= '0;
            num_q   <= '0;
            last_q  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            // bus is zero between beats
            tof_q   <= '0;
            int_q   <= '0;
            num_q   <= '0;
            last_q  <= 1'b0;
            valid_q <= 1'b0;
            case (state_q)
                RD_IDLE: begin
                    if (calc_done_i) begin
                        valid_q <= 1'b1;
                        num_q   <= count_i;
                        if (count_i == '0) begin
                            tof_q  <= `TDC_NO_HIT;   // empty frame still reports
                            last_q <= 1'b1;
                        end else begin
                            tof_q  <= result_i.tof;
                            int_q  <= result_i.intensity;
                            last_q <= (count_i == 2'd1);
                            if (count_i != 2'd1) begin
                                state_q <= RD_SEND;
                                idx_q   <= 2'd1;
                                cnt_q   <= count_i;
                            end
                        end
                    end
                end
                RD_SEND: begin
                    valid_q <= 1'b1;
                    num_q   <= cnt_q;
                    tof_q   <= result_i.tof;
                    int_q   <= result_i.intensity;
                    if (idx_q == cnt_q - 2'd1) begin   // final slot
                        last_q  <= 1'b1;
                        idx_q   <= '0;
                        state_q <= RD_IDLE;
                    end else begin
                        idx_q <= idx_q + 1'b1;
                    end
                end
                default: state_q <= RD_IDLE;
            endcase
        end
    end

    assign tof_o        = tof_q;
    assign int_o        = int_q;
    assign num_o        = num_q;
    assign last_o       = last_q;
    assign valid_o      = valid_q;
    assign burst_done_o = valid_q && last_q;

endmodule

`default_nettype wire

// File: logic/tdc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tdc_top import tdc_hit_pkg::*, tdc_out_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        start_i,
    input  tof_t       range_i,
    input  wire        hit_i,
    input  phase_t     phase_i,
    input  spad_t      spad_i,
    output tof_t       tof_o,
    output intensity_t int_o,
    output hit_cnt_t   num_o,
    output logic       last_o,
    output logic       valid_o
);

    // ----------------------------------------
    // frame timing
    // ----------------------------------------
    logic      frame_start;
    logic      active;
    coarse_t   coarse;
    logic      frame_end;
    tof_t      range_q;
    logic      burst_done;

    // capture into hit buffer
    logic      hit_wr_en;
    slot_idx_t hit_wr_idx;
    hit_t      hit_wr_data;
    fine_t     start_fine;
    hit_cnt_t  hit_cnt;

    // calc, hit buffer to result buffer
    slot_idx_t calc_rd_idx;
    hit_t      calc_hit;
    logic      res_wr_en;
    slot_idx_t res_wr_idx;
    result_t   res_wr_data;
    logic      calc_done;
    hit_cnt_t  calc_count;

    // readout side
    slot_idx_t out_rd_idx;
    result_t   out_result;

    tdc_frame_ctrl u_frame_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (start_i),
        .range_i       (range_i),
        .burst_done_i  (burst_done),
        .frame_start_o (frame_start),
        .active_o      (active),
        .coarse_o      (coarse),
        .frame_end_o   (frame_end),
        .range_o       (range_q)
    );

    tdc_hit_capture u_hit_capture (
        .clk           (clk),
        .rst_n         (rst_n),
        .frame_start_i (frame_start),
        .active_i      (active),
        .hit_i         (hit_i),
        .phase_i       (phase_i),
        .spad_i        (spad_i),
        .coarse_i      (coarse),
        .wr_en_o       (hit_wr_en),
        .wr_idx_o      (hit_wr_idx),
        .wr_hit_o      (hit_wr_data),
        .start_fine_o  (start_fine),
        .hit_cnt_o     (hit_cnt)
    );

    tdc_slot_buffer #(.payload_t(hit_t)) u_hit_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en_i   (hit_wr_en),
        .wr_idx_i  (hit_wr_idx),
        .wr_data_i (hit_wr_data),
        .rd_idx_i  (calc_rd_idx),
        .rd_data_o (calc_hit)
    );

    tdc_result_calc u_result_calc (
        .clk          (clk),
        .rst_n        (rst_n),
        .frame_end_i  (frame_end),
        .hit_cnt_i    (hit_cnt),
        .start_fine_i (start_fine),
        .range_i      (range_q),
        .rd_idx_o     (calc_rd_idx),
        .hit_i        (calc_hit),
        .wr_en_o      (res_wr_en),
        .wr_idx_o     (res_wr_idx),
        .wr_result_o  (res_wr_data),
        .calc_done_o  (calc_done),
        .count_o      (calc_count)
    );

    tdc_slot_buffer #(.payload_t(result_t)) u_res_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en_i   (res_wr_en),
        .wr_idx_i  (res_wr_idx),
        .wr_data_i (res_wr_data),
        .rd_idx_i  (out_rd_idx),
        .rd_data_o (out_result)
    );

    tdc_readout u_readout (
        .clk          (clk),
        .rst_n        (rst_n),
        .calc_done_i  (calc_done),
        .count_i      (calc_count),
        .rd_idx_o     (out_rd_idx),
        .result_i     (out_result),
        .tof_o        (tof_o),
        .int_o        (int_o),
        .num_o        (num_o),
        .last_o       (last_o),
        .valid_o      (valid_o),
        .burst_done_o (burst_done)
    );

endmodule

`default_nettype wire

// File: dv/tdc_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "tdc_macros.svh"

module tdc_tb import tdc_hit_pkg::*, tdc_out_pkg::*; ();

    localparam int NUM_FRAMES   = 7;
    localparam int HIT_SLOTS    = 4;    // one more than the dut keeps
    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES  = 20;
    localparam int FRAME_SLACK  = 20;   // start, calc latency, burst and gap

    logic       clk = 1'b0;
    logic       rst_n;
    logic       start_i;
    tof_t       range_i;
    logic       hit_i;
    phase_t     phase_i;
    spad_t      spad_i;
    tof_t       tof_o;
    intensity_t int_o;
    hit_cnt_t   num_o;
    logic       last_o;
    logic       valid_o;

    // ----------------------------------------
    // frame table and expected beats
    // ----------------------------------------
    tof_t  tbl_range    [NUM_FRAMES];
    int    tbl_stop     [NUM_FRAMES];              // stop fine, -1 draws one
    int    tbl_hit_at   [NUM_FRAMES][HIT_SLOTS];   // cycles after start, 0 unused
    spad_t tbl_spad     [NUM_FRAMES][HIT_SLOTS];
    logic  tbl_spad_set [NUM_FRAMES][HIT_SLOTS];
    int    tbl_beats    [NUM_FRAMES];              // burst length

    tof_t       exp_tof  [$];
    intensity_t exp_int  [$];
    hit_cnt_t   exp_num  [$];
    logic       exp_last [$];

    int          value_errors    = 0;
    int          protocol_errors = 0;
    int          beats_seen      = 0;
    int          beats_in_burst  = 0;
    int          frames_done     = 0;
    int          cycle_cnt       = 0;
    int          cycle_limit     = 0;

    always #2 clk = ~clk;

    tdc_top dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (start_i),
        .range_i (range_i),
        .hit_i   (hit_i),
        .phase_i (phase_i),
        .spad_i  (spad_i),
        .tof_o   (tof_o),
        .int_o   (int_o),
        .num_o   (num_o),
        .last_o  (last_o),
        .valid_o (valid_o)
    );

    // ----------------------------------------
    // reference rules
    // ----------------------------------------
    function automatic phase_t thermometer(input int fine);
        phase_t taps;
        taps = '0;
        for (int i = 0; i < fine; i++)
            taps[i] = 1'b1;
        return taps;
    endfunction

    // the 10-bit count wraps, so a zero coarse field runs a full turn
    function automatic int frame_cycles(input tof_t rng);
        int c;
        c = int'(rng) / `TDC_TAPS;
        return (c == 0) ? (1 << `TDC_COARSE_W) : c;
    endfunction

    function automatic tof_t expected_tof(input int coarse, input int stop, input int start,
                                          input tof_t rng);
        int raw;
        raw = coarse * `TDC_TAPS + stop - start;
        if (raw > int'(rng))
            return `TDC_NO_HIT;
        return tof_t'(raw);
    endfunction

    function automatic intensity_t expected_int(input spad_t en);
        int n;
        n = 0;
        for (int i = 0; i < `TDC_SPADS; i++)
            n += en[i];
        return (n > 15) ? intensity_t'(15) : intensity_t'(n);
    endfunction

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task automatic check_tof(input tof_t got, input tof_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error at %0t: tof_o is %0h, expected %0h", $time, got, exp);
        end
    endtask

    task automatic check_int(input intensity_t got, input intensity_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error at %0t: int_o is %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_num(input hit_cnt_t got, input hit_cnt_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error at %0t: num_o is %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_last(input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error at %0t: last_o is %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic check_beats(input int got, input int exp);
        if (got != exp) begin
            value_errors++;
            $display("Error at %0t: burst had %0d beats, expected %0d", $time, got, exp);
        end
    endtask

    // outputs settle after the rising edge, read them on the falling one
    always @(negedge clk) begin
        if (rst_n && valid_o) begin
            beats_seen++;
            if (exp_tof.size() == 0) begin
                protocol_errors++;
                $display("an output beat arrived at %0t with no beat expected", $time);
            end else begin
                check_tof(tof_o, exp_tof.pop_front());
                check_int(int_o, exp_int.pop_front());
                check_num(num_o, exp_num.pop_front());
                check_last(last_o, exp_last.pop_front());
            end
            if (last_o) begin
                beats_in_burst = beats_seen;
                beats_seen     = 0;
                frames_done++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: a burst did not finish within %0d cycles", cycle_limit);
            $display("test failed");
            $finish;
        end
    end

    task automatic set_frame(input int f, input tof_t rng, input int stop,
                             input int h0, input int h1, input int h2, input int h3,
                             input int beats);
        tbl_range[f]     = rng;
        tbl_stop[f]      = stop;
        tbl_hit_at[f][0] = h0;
        tbl_hit_at[f][1] = h1;
        tbl_hit_at[f][2] = h2;
        tbl_hit_at[f][3] = h3;
        tbl_beats[f]     = beats;
        for (int h = 0; h < HIT_SLOTS; h++) begin
            tbl_spad_set[f][h] = 1'b0;
            tbl_spad[f][h]     = '0;
        end
    endtask

    task automatic set_spad(input int f, input int h, input spad_t en);
        tbl_spad_set[f][h] = 1'b1;
        tbl_spad[f][h]     = en;
    endtask

    task automatic run_frame(input int f);
        fine_t      start_f;
        fine_t      stop_f   [HIT_SLOTS];
        spad_t      spads    [HIT_SLOTS];
        tof_t       beat_tof [HIT_SLOTS];
        intensity_t beat_int [HIT_SLOTS];
        int         n_acc;
        int         last_k;
        int         done_before;
        start_f     = fine_t'($urandom);
        n_acc       = 0;
        last_k      = 0;
        done_before = frames_done;
        for (int h = 0; h < HIT_SLOTS; h++) begin
            stop_f[h] = (tbl_stop[f] >= 0) ? fine_t'(tbl_stop[f]) : fine_t'($urandom);
            spads[h]  = tbl_spad_set[f][h] ? tbl_spad[f][h] : spad_t'($urandom);
            if (tbl_hit_at[f][h] > last_k)
                last_k = tbl_hit_at[f][h];
            // inside the window and among the first three
            if (tbl_hit_at[f][h] > 0 && tbl_hit_at[f][h] < frame_cycles(tbl_range[f])
                    && n_acc < `TDC_MAX_HITS) begin
                beat_tof[n_acc] = expected_tof(tbl_hit_at[f][h], stop_f[h], start_f,
                                               tbl_range[f]);
                beat_int[n_acc] = expected_int(spads[h]);
                n_acc++;
            end
        end
        if (n_acc == 0) begin
            exp_tof.push_back(`TDC_NO_HIT);
            exp_int.push_back(intensity_t'(0));
            exp_num.push_back(hit_cnt_t'(0));
            exp_last.push_back(1'b1);
        end else begin
            for (int b = 0; b < n_acc; b++) begin
                exp_tof.push_back(beat_tof[b]);
                exp_int.push_back(beat_int[b]);
                exp_num.push_back(hit_cnt_t'(n_acc));
                exp_last.push_back(b == n_acc - 1);
            end
        end

        @(posedge clk);
        start_i <= 1'b1;
        range_i <= tbl_range[f];
        phase_i <= thermometer(start_f);
        for (int k = 1; k <= last_k; k++) begin
            @(posedge clk);
            start_i <= 1'b0;
            hit_i   <= 1'b0;
            for (int h = 0; h < HIT_SLOTS; h++) begin
                if (tbl_hit_at[f][h] == k) begin
                    hit_i   <= 1'b1;
                    phase_i <= thermometer(stop_f[h]);
                    spad_i  <= spads[h];
                end
            end
        end
        @(posedge clk);
        start_i <= 1'b0;
        hit_i   <= 1'b0;
        while (frames_done == done_before)
            @(posedge clk);
        check_beats(beats_in_burst, tbl_beats[f]);
        repeat (3) @(posedge clk);   // busy drops after the final beat
    endtask

    initial begin
        void'($urandom(32'h9c71_f823));
        rst_n    = 1'b0;
        start_i  = 1'b0;
        range_i  = '0;
        hit_i    = 1'b0;
        phase_i  = '0;
        spad_i   = '0;

        //          range      stop  hit offsets          beats
        set_frame(0, 15'd200,  -1,   0,  0,    0,  0,     1);   // empty frame
        set_frame(1, 15'd600,  -1,   5,  0,    0,  0,     1);
        set_frame(2, 15'd640,  -1,   3,  9,    0,  0,     2);
        set_frame(3, 15'd1000, -1,   2,  10,   20, 0,     3);
        set_frame(4, 15'd800,  -1,   4,  6,    8,  12,    3);   // fourth hit dropped
        set_frame(5, 15'd300,  -1,   3,  9,    0,  0,     1);   // 9 is the end cycle
        set_frame(6, 15'd20,   31,   1,  1023, 0,  0,     2);   // beyond range
        set_spad(3, 1, 16'h0000);
        set_spad(6, 0, 16'hffff);
        set_spad(6, 1, 16'hffff);

        cycle_limit = RESET_CYCLES + IDLE_CYCLES;
        for (int f = 0; f < NUM_FRAMES; f++)
            cycle_limit += frame_cycles(tbl_range[f]) + FRAME_SLACK;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (IDLE_CYCLES) @(posedge clk);   // no start, no beats

        for (int f = 0; f < NUM_FRAMES; f++)
            run_frame(f);

        repeat (5) @(posedge clk);
        if (exp_tof.size() != 0) begin
            protocol_errors++;
            $display("%0d expected beats never came out of the dut", exp_tof.size());
        end
        $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tdc_top.f
+incdir+logic
logic/tdc_hit_pkg.sv
logic/tdc_out_pkg.sv
logic/tdc_frame_ctrl.sv
logic/tdc_hit_capture.sv
logic/tdc_slot_buffer.sv
logic/tdc_result_calc.sv
logic/tdc_readout.sv
logic/tdc_top.sv
dv/tdc_tb.sv

// File: Bender.yml
package:
  name: tdc_top

export_include_dirs:
  - logic

sources:
  - logic/tdc_hit_pkg.sv
  - logic/tdc_out_pkg.sv
  - logic/tdc_frame_ctrl.sv
  - logic/tdc_hit_capture.sv
  - logic/tdc_slot_buffer.sv
  - logic/tdc_result_calc.sv
  - logic/tdc_readout.sv
  - logic/tdc_top.sv
  - target: test
    files:
      - dv/tdc_tb.sv
